// ==== src/soc_pkg.sv ====
/*
  SoC peripheral subsystem shared definitions
  Bus widths, region map, CLINT register offsets and the address view
*/
package soc_pkg;

  // ----------------------------
  // Bus widths
  // ----------------------------
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 64;
  localparam int BE_W       = 8;
  localparam int REGION_W   = 4;
  localparam int OFS_W      = ADDR_W - REGION_W;
  // Byte address bits below one data word
  localparam int BYTE_OFS_W = $clog2(BE_W);

  // ----------------------------
  // Region map, top address nibble
  // ----------------------------
  localparam logic [REGION_W-1:0] REGION_ROM   = 4'h1;
  localparam logic [REGION_W-1:0] REGION_CLINT = 4'h2;
  localparam logic [REGION_W-1:0] REGION_SPM   = 4'h8;

  // Memory sizes in data words
  localparam int ROM_WORDS  = 16;
  localparam int ROM_IDX_W  = $clog2(ROM_WORDS);
  localparam int SPM_WORDS  = 256;
  localparam int SPM_IDX_W  = $clog2(SPM_WORDS);

  // Boot image, path relative to the project root
  localparam string ROM_HEX_FILE = "src/boot_rom.hex";

  // CLINT byte offsets inside its region
  localparam logic [OFS_W-1:0] CLINT_MSIP_OFS     = 28'h000_0000;
  localparam logic [OFS_W-1:0] CLINT_MTIMECMP_OFS = 28'h000_4000;
  localparam logic [OFS_W-1:0] CLINT_MTIME_OFS    = 28'h000_BFF8;

  // Debug request hold-off after reset
  localparam int DBG_DELAY_CYCLES = 500;
  localparam int DBG_CNT_W        = $clog2(DBG_DELAY_CYCLES + 1);

  // Address seen either as one word or as region plus offset
  typedef union packed {
    logic [ADDR_W-1:0] word;
    struct packed {
      logic [REGION_W-1:0] region;
      logic [OFS_W-1:0]    ofs;
    } fields;
  } soc_addr_u;

endpackage

// ==== src/periph_xbar.sv ====
/*
  Peripheral crossbar
  Decodes one request port onto ROM, CLINT and SPM, flags unmapped
  and ROM-write errors, and returns one registered response per request
*/
`timescale 1ns/1ps

module periph_xbar import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  // Master request
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic              req_we_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  input  logic [BE_W-1:0]   req_be_i,
  // Master response
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output logic [DATA_W-1:0] rsp_rdata_o,
  output logic              rsp_err_o,
  // Shared target request lines
  output logic              tgt_we_o,
  output logic [OFS_W-1:0]  tgt_ofs_o,
  output logic [DATA_W-1:0] tgt_wdata_o,
  output logic [BE_W-1:0]   tgt_be_o,
  // Target selects and read data
  output logic              rom_sel_o,
  output logic              spm_sel_o,
  output logic              clint_sel_o,
  input  logic [DATA_W-1:0] rom_rdata_i,
  input  logic [DATA_W-1:0] spm_rdata_i,
  input  logic [DATA_W-1:0] clint_rdata_i
);

  soc_addr_u addr;
  logic      hit_rom;
  logic      hit_clint;
  logic      hit_spm;
  logic      req_err;
  logic      req_fire;

  logic      rsp_valid_q;
  logic      rsp_err_q;
  // Which target owns the pending read data
  logic      rd_rom_q;
  logic      rd_spm_q;
  logic      rd_clint_q;

  // ----------------------------
  // Address decode
  // ----------------------------
  assign addr.word = req_addr_i;

  assign hit_rom   = (addr.fields.region == REGION_ROM);
  assign hit_clint = (addr.fields.region == REGION_CLINT);
  assign hit_spm   = (addr.fields.region == REGION_SPM);

  // Unmapped region, or an attempt to write the ROM
  assign req_err = !(hit_rom || hit_clint || hit_spm) || (hit_rom && req_we_i);

  // One slot; it frees up when the held response leaves this cycle
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  assign rom_sel_o   = req_fire && hit_rom && !req_we_i;
  assign spm_sel_o   = req_fire && hit_spm;
  assign clint_sel_o = req_fire && hit_clint;

  assign tgt_we_o    = req_we_i;
  assign tgt_ofs_o   = addr.fields.ofs;
  assign tgt_wdata_o = req_wdata_i;
  assign tgt_be_o    = req_be_i;

  // ----------------------------
  // Response stage
  // ----------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
      rd_rom_q    <= 1'b0;
      rd_spm_q    <= 1'b0;
      rd_clint_q  <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
      rsp_err_q   <= req_err;
      rd_rom_q    <= rom_sel_o;
      rd_spm_q    <= spm_sel_o && !req_we_i;
      rd_clint_q  <= clint_sel_o && !req_we_i;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = rsp_err_q;

  // Targets keep their read word until selected again
  always_comb begin
    rsp_rdata_o = '0;
    if (rd_rom_q) begin
      rsp_rdata_o = rom_rdata_i;
    end else if (rd_spm_q) begin
      rsp_rdata_o = spm_rdata_i;
    end else if (rd_clint_q) begin
      rsp_rdata_o = clint_rdata_i;
    end
  end

endmodule

// ==== src/boot_rom.sv ====
/*
  Boot ROM
  Fixed table of 64-bit words loaded from the boot image,
  read with one cycle of latency
*/
`timescale 1ns/1ps

module boot_rom import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              sel_i,
  input  logic [OFS_W-1:0]  ofs_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0]    rom_q [ROM_WORDS];
  logic [ROM_IDX_W-1:0] idx;

  // Image is fixed at elaboration
  initial begin
    $readmemh(ROM_HEX_FILE, rom_q);
  end

  // Word index, upper offset bits wrap
  assign idx = ofs_i[BYTE_OFS_W +: ROM_IDX_W];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= rom_q[idx];
    end
  end

endmodule

// ==== src/spm_ram.sv ====
/*
  Scratchpad RAM
  Single-port word memory with per-byte write enables
  and a registered read port
*/
`timescale 1ns/1ps

module spm_ram import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              sel_i,
  input  logic              we_i,
  input  logic [OFS_W-1:0]  ofs_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [BE_W-1:0]   be_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0]    mem_q [SPM_WORDS];
  logic [SPM_IDX_W-1:0] idx;

  // Word index, offset wraps at the RAM size
  assign idx = ofs_i[BYTE_OFS_W +: SPM_IDX_W];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        // Only enabled lanes change
        for (int b = 0; b < BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

endmodule

// ==== src/clint_timer.sv ====
/*
  Core-local interruptor
  mtime, mtimecmp and msip registers; mtime advances on every second
  synchronised rtc edge and drives the timer and software interrupts
*/
`timescale 1ns/1ps

module clint_timer import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              sel_i,
  input  logic              we_i,
  input  logic [OFS_W-1:0]  ofs_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic              rtc_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  logic [DATA_W-1:0] mtime_q;
  logic [DATA_W-1:0] mtimecmp_q;
  logic              msip_q;
  logic              timer_irq_q;
  // Two sync flops plus one history flop
  logic [2:0]        rtc_sync_q;
  logic              rtc_div_q;
  logic              rtc_rise;
  logic              mtime_tick;
  logic              hit_msip;
  logic              hit_cmp;
  logic              hit_time;
  logic [DATA_W-1:0] rd_word;

  // Merge enabled byte lanes of a new value into an old one
  function automatic logic [DATA_W-1:0] be_merge(
    input logic [DATA_W-1:0] old_v,
    input logic [DATA_W-1:0] new_v,
    input logic [BE_W-1:0]   be
  );
    logic [DATA_W-1:0] res;
    res = old_v;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_v[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // ----------------------------
  // rtc edge and divide by two
  // ----------------------------
  assign rtc_rise   = rtc_sync_q[1] && !rtc_sync_q[2];
  assign mtime_tick = rtc_rise && rtc_div_q;

  // Register decode on word address
  assign hit_msip = (ofs_i[OFS_W-1:BYTE_OFS_W] == CLINT_MSIP_OFS[OFS_W-1:BYTE_OFS_W]);
  assign hit_cmp  = (ofs_i[OFS_W-1:BYTE_OFS_W] == CLINT_MTIMECMP_OFS[OFS_W-1:BYTE_OFS_W]);
  assign hit_time = (ofs_i[OFS_W-1:BYTE_OFS_W] == CLINT_MTIME_OFS[OFS_W-1:BYTE_OFS_W]);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q  <= '0;
      rtc_div_q   <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[1:0], rtc_i};
      if (rtc_rise) begin
        rtc_div_q <= !rtc_div_q;
      end
      // Bus write wins over the tick
      if (sel_i && we_i && hit_time) begin
        mtime_q <= be_merge(mtime_q, wdata_i, be_i);
      end else if (mtime_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (sel_i && we_i && hit_cmp) begin
        mtimecmp_q <= be_merge(mtimecmp_q, wdata_i, be_i);
      end
      if (sel_i && we_i && hit_msip && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // ----------------------------
  // Read port
  // ----------------------------
  always_comb begin
    rd_word = '0;
    if (hit_msip) begin
      rd_word[0] = msip_q;
    end else if (hit_cmp) begin
      rd_word = mtimecmp_q;
    end else if (hit_time) begin
      rd_word = mtime_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i && !we_i) begin
      rdata_o <= rd_word;
    end
  end

  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

endmodule

// ==== src/debug_gate.sv ====
/*
  Debug request gate
  Keeps the debug request low for a fixed number of cycles after reset
*/
`timescale 1ns/1ps

module debug_gate import soc_pkg::*; (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [DBG_CNT_W-1:0] cnt_q;
  logic                 cnt_done;

  assign cnt_done = (cnt_q == '0);

  // Counts down once per cycle and parks at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= DBG_CNT_W'(DBG_DELAY_CYCLES);
    end else if (!cnt_done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = cnt_done && debug_req_i;

endmodule

// ==== src/soc_subsys_top.sv ====
/*
  SoC peripheral subsystem
  Crossbar with boot ROM, scratchpad, CLINT and the debug request gate
*/
`timescale 1ns/1ps

module soc_subsys_top import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic              req_we_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  input  logic [BE_W-1:0]   req_be_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output logic [DATA_W-1:0] rsp_rdata_o,
  output logic              rsp_err_o,
  input  logic              rtc_i,
  output logic              timer_irq_o,
  output logic              ipi_o,
  input  logic              debug_req_i,
  output logic              debug_req_o
);

  logic              tgt_we;
  logic [OFS_W-1:0]  tgt_ofs;
  logic [DATA_W-1:0] tgt_wdata;
  logic [BE_W-1:0]   tgt_be;
  logic              rom_sel;
  logic              spm_sel;
  logic              clint_sel;
  logic [DATA_W-1:0] rom_rdata;
  logic [DATA_W-1:0] spm_rdata;
  logic [DATA_W-1:0] clint_rdata;

  // ----------------------------
  // Bus
  // ----------------------------
  periph_xbar i_xbar (
    .clk_i,
    .ndmreset_n,
    .req_valid_i,
    .req_ready_o,
    .req_addr_i,
    .req_we_i,
    .req_wdata_i,
    .req_be_i,
    .rsp_valid_o,
    .rsp_ready_i,
    .rsp_rdata_o,
    .rsp_err_o,
    .tgt_we_o      ( tgt_we      ),
    .tgt_ofs_o     ( tgt_ofs     ),
    .tgt_wdata_o   ( tgt_wdata   ),
    .tgt_be_o      ( tgt_be      ),
    .rom_sel_o     ( rom_sel     ),
    .spm_sel_o     ( spm_sel     ),
    .clint_sel_o   ( clint_sel   ),
    .rom_rdata_i   ( rom_rdata   ),
    .spm_rdata_i   ( spm_rdata   ),
    .clint_rdata_i ( clint_rdata )
  );

  // ----------------------------
  // Targets
  // ----------------------------
  boot_rom i_boot_rom (
    .clk_i,
    .sel_i   ( rom_sel   ),
    .ofs_i   ( tgt_ofs   ),
    .rdata_o ( rom_rdata )
  );

  spm_ram i_spm_ram (
    .clk_i,
    .sel_i   ( spm_sel   ),
    .we_i    ( tgt_we    ),
    .ofs_i   ( tgt_ofs   ),
    .wdata_i ( tgt_wdata ),
    .be_i    ( tgt_be    ),
    .rdata_o ( spm_rdata )
  );

  clint_timer i_clint (
    .clk_i,
    .ndmreset_n,
    .sel_i   ( clint_sel   ),
    .we_i    ( tgt_we      ),
    .ofs_i   ( tgt_ofs     ),
    .wdata_i ( tgt_wdata   ),
    .be_i    ( tgt_be      ),
    .rtc_i,
    .rdata_o ( clint_rdata ),
    .timer_irq_o,
    .ipi_o
  );

  // Hold-off window so boot code runs before a debug halt
  debug_gate i_debug_gate (
    .clk_i,
    .ndmreset_n,
    .debug_req_i,
    .debug_req_o
  );

endmodule

// ==== bench/soc_subsys_props.sv ====
/*
  Response handshake and reset state properties for the subsystem top
*/
`timescale 1ns/1ps

module soc_subsys_props import soc_pkg::*; (
  input logic              clk_i,
  input logic              ndmreset_n,
  input logic              req_ready_o,
  input logic              rsp_valid_o,
  input logic              rsp_ready_i,
  input logic [DATA_W-1:0] rsp_rdata_o,
  input logic              rsp_err_o,
  input logic              timer_irq_o,
  input logic              ipi_o
);

  // Held response keeps its payload
  assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_err_o))
    else $error("response changed while held");

  // No new request while a response is stuck
  assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rsp_valid_o && !rsp_ready_i |-> !req_ready_o)
    else $error("request accepted while response held");

  assert property (@(posedge clk_i) $rose(ndmreset_n) |-> !timer_irq_o && !ipi_o)
    else $error("interrupt active right after reset");

endmodule

bind soc_subsys_top soc_subsys_props i_props (.*);

// ==== bench/tb_clkgen.sv ====
/*
  Testbench clock and reset
  10 ns clock, reset held low for the first 4 rising edges
*/
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

// ==== bench/tb_checker.sv ====
/*
  Testbench checker
  Reference model of ROM, scratchpad and CLINT; compares responses in
  order and watches the interrupts and the debug gate every cycle
*/
`timescale 1ns/1ps

module tb_checker import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              req_valid_i,
  input  logic              req_ready_o,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic              req_we_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  input  logic [BE_W-1:0]   req_be_i,
  input  logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  input  logic [DATA_W-1:0] rsp_rdata_o,
  input  logic              rsp_err_o,
  input  logic              rtc_i,
  input  logic              timer_irq_o,
  input  logic              ipi_o,
  input  logic              debug_req_i,
  input  logic              debug_req_o,
  output int                data_errs_o,
  output int                irq_errs_o,
  output int                gate_errs_o,
  output int                order_errs_o,
  output int                pending_o
);

  logic [DATA_W-1:0] rom_m [16];
  logic [DATA_W-1:0] ram_m [256];
  logic [DATA_W-1:0] exp_rdata_q [$];
  logic              exp_err_q [$];
  logic [DATA_W-1:0] mtime_m;
  logic [DATA_W-1:0] cmp_m;
  logic              msip_m;
  logic              irq_m;
  logic [2:0]        sync_m;
  logic              div_m;
  int                gate_cnt;

  initial begin
    $readmemh("src/boot_rom.hex", rom_m);
    data_errs_o  = 0;
    irq_errs_o   = 0;
    gate_errs_o  = 0;
    order_errs_o = 0;
  end

  assign pending_o = exp_rdata_q.size();

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_v,
                                                    input logic [DATA_W-1:0] new_v,
                                                    input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] res;
    res = old_v;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) res[b*8 +: 8] = new_v[b*8 +: 8];
    end
    return res;
  endfunction

  always @(posedge clk_i) begin
    logic [3:0]        region;
    logic [27:0]       ofs;
    logic [24:0]       word;
    logic [DATA_W-1:0] exp_d;
    logic              exp_e;
    logic              exp_valid;
    logic              exp_ready;
    logic              rise;
    logic              tick;
    logic              irq_next;
    logic              gate_exp;
    if (!ndmreset_n) begin
      exp_rdata_q.delete();
      exp_err_q.delete();
      mtime_m  = '0;
      cmp_m    = '1;
      msip_m   = 1'b0;
      irq_m    = 1'b0;
      sync_m   = '0;
      div_m    = 1'b0;
      gate_cnt = 0;
    end else begin
      // Pending response and free slot as the model's queue sees them
      exp_valid = (exp_rdata_q.size() != 0);
      exp_ready = !exp_valid || rsp_ready_i;
      if (rsp_valid_o !== exp_valid) begin
        $display("CHECK FAILED rsp_valid_o exp %h got %h", exp_valid, rsp_valid_o);
        order_errs_o++;
      end
      if (req_ready_o !== exp_ready) begin
        $display("CHECK FAILED req_ready_o exp %h got %h", exp_ready, req_ready_o);
        order_errs_o++;
      end

      // Outgoing response against the oldest expectation
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_rdata_q.size() == 0) begin
          $display("Response arrived with no request outstanding");
          order_errs_o++;
        end else begin
          exp_d = exp_rdata_q.pop_front();
          exp_e = exp_err_q.pop_front();
          if (rsp_rdata_o !== exp_d) begin
            $display("CHECK FAILED rsp_rdata_o exp %h got %h", exp_d, rsp_rdata_o);
            data_errs_o++;
          end
          if (rsp_err_o !== exp_e) begin
            $display("CHECK FAILED rsp_err_o exp %h got %h", exp_e, rsp_err_o);
            data_errs_o++;
          end
        end
      end

      if (timer_irq_o !== irq_m) begin
        $display("CHECK FAILED timer_irq_o exp %h got %h", irq_m, timer_irq_o);
        irq_errs_o++;
      end
      if (ipi_o !== msip_m) begin
        $display("CHECK FAILED ipi_o exp %h got %h", msip_m, ipi_o);
        irq_errs_o++;
      end
      gate_exp = (gate_cnt >= 500) ? debug_req_i : 1'b0;
      if (debug_req_o !== gate_exp) begin
        $display("CHECK FAILED debug_req_o exp %h got %h", gate_exp, debug_req_o);
        gate_errs_o++;
      end
      if (gate_cnt < 500) gate_cnt++;

      // Timer state as seen before this edge
      irq_next = (mtime_m >= cmp_m);
      rise     = sync_m[1] && !sync_m[2];
      tick     = rise && div_m;
      sync_m   = {sync_m[1:0], rtc_i};
      if (rise) div_m = !div_m;
      if (tick) mtime_m = mtime_m + 64'd1;

      if (req_valid_i && req_ready_o) begin
        region = req_addr_i[31:28];
        ofs    = req_addr_i[27:0];
        word   = ofs[27:3];
        exp_d  = '0;
        exp_e  = 1'b0;
        if (region == 4'h1) begin
          if (req_we_i) exp_e = 1'b1;
          else exp_d = rom_m[word[3:0]];
        end else if (region == 4'h8) begin
          if (req_we_i) ram_m[word[7:0]] = merge_bytes(ram_m[word[7:0]], req_wdata_i, req_be_i);
          else exp_d = ram_m[word[7:0]];
        end else if (region == 4'h2) begin
          if (word == 25'h0) begin
            if (!req_we_i) exp_d = {63'd0, msip_m};
            else if (req_be_i[0]) msip_m = req_wdata_i[0];
          end else if (word == 25'h800) begin
            if (!req_we_i) exp_d = cmp_m;
            else cmp_m = merge_bytes(cmp_m, req_wdata_i, req_be_i);
          end else if (word == 25'h17FF) begin
            // Read sees the value before this edge's tick
            if (!req_we_i) exp_d = tick ? mtime_m - 64'd1 : mtime_m;
            else mtime_m = merge_bytes(tick ? mtime_m - 64'd1 : mtime_m, req_wdata_i, req_be_i);
          end
        end else begin
          exp_e = 1'b1;
        end
        exp_rdata_q.push_back(exp_d);
        exp_err_q.push_back(exp_e);
      end
      irq_m = irq_next;
    end
  end

endmodule

// ==== bench/tb_top.sv ====
/*
  Subsystem testbench top
  Random bus traffic, directed CLINT sequences, watchdog and summary
*/
`timescale 1ns/1ps

module tb_top import soc_pkg::*;;

  localparam int N_RAND         = 400;
  localparam int TOTAL_TXN      = 256 + 10 + N_RAND;
  localparam int TIMEOUT_CYCLES = TOTAL_TXN * 20 + 2000;

  logic clk_i, ndmreset_n;
  logic req_valid_i, req_ready_o, req_we_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic [DATA_W-1:0] req_wdata_i, rsp_rdata_o;
  logic [BE_W-1:0] req_be_i;
  logic rsp_valid_o, rsp_ready_i, rsp_err_o;
  logic rtc_i, timer_irq_o, ipi_o, debug_req_i, debug_req_o;
  int data_errs, irq_errs, gate_errs, order_errs, pending;
  int seed;

  tb_clkgen i_clkgen (.clk_o(clk_i), .rst_n_o(ndmreset_n));

  soc_subsys_top UUT (.*);

  tb_checker i_checker (
    .*,
    .data_errs_o  ( data_errs  ),
    .irq_errs_o   ( irq_errs   ),
    .gate_errs_o  ( gate_errs  ),
    .order_errs_o ( order_errs ),
    .pending_o    ( pending    )
  );

  // Caller sits on a rising edge; returns on the accepting edge
  task automatic send_req(input logic [31:0] addr, input logic we,
                          input logic [63:0] wdata, input logic [7:0] be);
    req_valid_i <= 1'b1;
    req_addr_i  <= addr;
    req_we_i    <= we;
    req_wdata_i <= wdata;
    req_be_i    <= be;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
  endtask

  task automatic idle_bus(input int cycles);
    req_valid_i <= 1'b0;
    repeat (cycles) @(posedge clk_i);
  endtask

  // Mix of ROM, SPM, CLINT registers and unmapped regions
  function automatic logic [31:0] pick_addr();
    int         sel;
    logic [3:0] reg4;
    sel = {$random(seed)} % 8;
    case (sel)
      0, 1: return {4'h1, 28'({$random(seed)} & 32'h0FF)};
      2, 3: return {4'h8, 28'({$random(seed)} & 32'h7FF)};
      4, 5: begin
        sel = {$random(seed)} % 4;
        if (sel == 0) return {4'h2, 28'h000_0000 | 28'({$random(seed)} & 7)};
        if (sel == 1) return {4'h2, 28'h000_4000};
        if (sel == 2) return {4'h2, 28'h000_BFF8};
        return {4'h2, 28'({$random(seed)} & 32'hFFFF)};
      end
      default: begin
        reg4 = 4'({$random(seed)} % 16);
        if (reg4 == 4'h1 || reg4 == 4'h2 || reg4 == 4'h8) reg4 = 4'hF;
        return {reg4, 28'($random(seed))};
      end
    endcase
  endfunction

  initial begin
    seed        = 32'h7181_129b;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_we_i    = 1'b0;
    req_wdata_i = '0;
    req_be_i    = '0;
    rsp_ready_i = 1'b1;
    debug_req_i = 1'b1;
    wait (ndmreset_n);
    @(posedge clk_i);
    // Fill the whole scratchpad first
    for (int i = 0; i < 256; i++) begin
      send_req({4'h8, 28'(i * 8)}, 1'b1, {$random(seed), $random(seed)}, 8'hFF);
    end
    send_req({4'h2, 28'h0}, 1'b1, 64'h1, 8'hFF);
    send_req({4'h2, 28'h0}, 1'b0, 64'h0, 8'hFF);
    send_req({4'h2, 28'h4000}, 1'b1, 64'h0, 8'hFF);
    idle_bus(4);
    send_req({4'h2, 28'h4000}, 1'b1, '1, 8'hFF);
    idle_bus(4);
    // mtime write, then rtc edges with the bus quiet
    send_req({4'h2, 28'hBFF8}, 1'b1, 64'h100, 8'hFF);
    req_valid_i <= 1'b0;
    repeat (6) @(posedge rtc_i);
    @(posedge clk_i);
    idle_bus(4);
    send_req({4'h2, 28'hBFF8}, 1'b0, 64'h0, 8'hFF);
    send_req({4'h2, 28'h0}, 1'b1, 64'h0, 8'hFF);
    for (int i = 0; i < N_RAND; i++) begin
      send_req(pick_addr(), ({$random(seed)} % 5) < 2, {$random(seed), $random(seed)},
               8'($random(seed)));
      if (({$random(seed)} % 4) == 0) idle_bus(1 + {$random(seed)} % 3);
    end
    idle_bus(1);
    while (pending != 0) @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    $display("Errors: data %0d irq %0d gate %0d order %0d",
             data_errs, irq_errs, gate_errs, order_errs);
    if (data_errs + irq_errs + gate_errs + order_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    rsp_ready_i <= ({$random(seed)} % 4) != 0;
  end

  // Slow rtc, each level held 4 to 11 cycles
  initial begin
    int hold;
    rtc_i = 1'b0;
    forever begin
      hold = 4 + {$random(seed)} % 8;
      repeat (hold) @(posedge clk_i);
      rtc_i <= !rtc_i;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not complete in %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== src/boot_rom.hex ====
// Boot ROM image: one 64-bit word per line in hex, word index 0 first
0000_0297_0202_8293
0182_b283_0002_8067
1050_0073_ffdf_f06f
0000_0000_0000_0013
a5a5_5a5a_0f0f_f0f0
1234_5678_9abc_def0
0fed_cba9_8765_4321
dead_beef_cafe_f00d
0101_0202_0303_0404
8000_0000_0000_0001
7fff_ffff_ffff_fffe
3c3c_c3c3_9696_6969
0000_ffff_0000_ffff
ffff_0000_ffff_0000
5555_aaaa_3333_cccc
0bad_c0de_1bad_b002

// ==== flist.f ====
src/soc_pkg.sv
src/periph_xbar.sv
src/boot_rom.sv
src/spm_ram.sv
src/clint_timer.sv
src/debug_gate.sv
src/soc_subsys_top.sv
bench/soc_subsys_props.sv
bench/tb_clkgen.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and judge the result from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f || exit 1
./obj_dir/Vtb_top > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
